/* design/pin_bridge_consts.svh */
`ifndef PIN_BRIDGE_CONSTS_SVH
`define PIN_BRIDGE_CONSTS_SVH

// stream and register widths
`define PB_BYTE_W     8
`define PB_NUM_PORTS  8
`define PB_IDX_W      3

// opcode high nibbles
`define PB_GRP_STROBE   4'h1
`define PB_GRP_PIN_RD   4'h2
`define PB_GRP_PIN_WR   4'h3
`define PB_GRP_REG_WR   4'h4
`define PB_GRP_REG_RD   4'h5
`define PB_GRP_PIN_REL  4'h6

// strobe group low nibbles
`define PB_STROBE_CLK_SET  4'h0
`define PB_STROBE_CLK_CLR  4'h1
`define PB_STROBE_RST_SET  4'h2
`define PB_STROBE_RST_CLR  4'h3

`endif

/* design/pin_bridge_pkg.sv */
`include "pin_bridge_consts.svh"

package pin_bridge_pkg;

  typedef logic [`PB_BYTE_W-1:0]               byte_t;
  typedef logic [`PB_IDX_W-1:0]                port_idx_t;
  typedef logic [`PB_NUM_PORTS-1:0]            port_mask_t;
  typedef logic [`PB_NUM_PORTS*`PB_BYTE_W-1:0] port_array_t; // port 0 in low byte

  typedef enum logic [3:0] {
    GRP_NONE    = 4'h0,
    GRP_STROBE  = `PB_GRP_STROBE,
    GRP_PIN_RD  = `PB_GRP_PIN_RD,
    GRP_PIN_WR  = `PB_GRP_PIN_WR,
    GRP_REG_WR  = `PB_GRP_REG_WR,
    GRP_REG_RD  = `PB_GRP_REG_RD,
    GRP_PIN_REL = `PB_GRP_PIN_REL,
    GRP_UNKNOWN = 4'hf
  } cmd_grp_e;

  typedef enum logic [2:0] {
    IDLE,
    EXEC,
    WAIT_DATA,
    WAIT_RESP,
    DONE
  } seq_state_e;

  typedef struct packed {
    cmd_grp_e  grp;
    port_idx_t idx;
  } cmd_t;

  typedef struct packed {
    logic      wr;   // drive data and enable
    logic      rel;  // clear enable only
    port_idx_t idx;
    byte_t     data;
  } port_wr_t;

  typedef struct packed {
    logic      wr;
    port_idx_t idx;
    byte_t     data;
  } reg_wr_t;

endpackage

/* design/cmd_receiver.sv */
`include "pin_bridge_consts.svh"

module cmd_receiver (
  input  logic                  sys_clk,
  input  logic                  sys_rst_n,
  input  pin_bridge_pkg::byte_t rx_byte,
  input  logic                  rx_valid,
  input  logic                  accept_cmd,
  input  logic                  accept_data,
  output logic                  rx_ready,
  output pin_bridge_pkg::cmd_t  cmd,
  output logic                  cmd_valid,
  output pin_bridge_pkg::byte_t data,
  output logic                  data_valid
);

  pin_bridge_pkg::cmd_t dec_cmd;
  logic                 take;

  assign rx_ready = accept_cmd | accept_data; // open only on request
  assign take     = rx_valid & rx_ready;

  always_comb begin
    dec_cmd.idx = rx_byte[`PB_IDX_W-1:0];
    case (rx_byte[7:4])
      4'h0: begin
        dec_cmd.grp = (rx_byte == '0) ? pin_bridge_pkg::GRP_NONE : pin_bridge_pkg::GRP_UNKNOWN;
      end
      `PB_GRP_STROBE: begin
        dec_cmd.grp = (rx_byte[3:0] <= `PB_STROBE_RST_CLR) ? pin_bridge_pkg::GRP_STROBE
                                                            : pin_bridge_pkg::GRP_UNKNOWN;
      end
      `PB_GRP_PIN_RD, `PB_GRP_PIN_WR, `PB_GRP_REG_WR, `PB_GRP_REG_RD, `PB_GRP_PIN_REL: begin
        // only indices 0..7 are valid
        dec_cmd.grp = rx_byte[3] ? pin_bridge_pkg::GRP_UNKNOWN
                                 : pin_bridge_pkg::cmd_grp_e'(rx_byte[7:4]);
      end
      default: dec_cmd.grp = pin_bridge_pkg::GRP_UNKNOWN;
    endcase
  end

  always_ff @(posedge sys_clk or negedge sys_rst_n) begin
    if (!sys_rst_n) begin
      cmd_valid  <= 1'b0;
      data_valid <= 1'b0;
    end else begin
      cmd_valid  <= take & accept_cmd & (dec_cmd.grp != pin_bridge_pkg::GRP_NONE); // 0x00 dropped
      data_valid <= take & accept_data;
    end
  end

  always_ff @(posedge sys_clk) begin
    if (take && accept_cmd) cmd <= dec_cmd;
    if (take && accept_data) data <= rx_byte;
  end

endmodule

/* design/cmd_sequencer.sv */
`include "pin_bridge_consts.svh"

module cmd_sequencer (
  input  logic                      sys_clk,
  input  logic                      sys_rst_n,
  input  pin_bridge_pkg::cmd_t      cmd,
  input  logic                      cmd_valid,
  input  pin_bridge_pkg::byte_t     data,
  input  logic                      data_valid,
  input  logic                      resp_ready,
  input  pin_bridge_pkg::byte_t     pin_sample,
  input  pin_bridge_pkg::byte_t     reg_value,
  output logic                      accept_cmd,
  output logic                      accept_data,
  output pin_bridge_pkg::port_wr_t  port_wr,
  output pin_bridge_pkg::reg_wr_t   reg_wr,
  output pin_bridge_pkg::port_idx_t rd_idx,
  output logic                      resp_valid,
  output pin_bridge_pkg::byte_t     resp_byte,
  output logic                      target_clk,
  output logic                      target_rst,
  output logic                      busy
);

  pin_bridge_pkg::seq_state_e state;
  pin_bridge_pkg::seq_state_e state_nxt;
  pin_bridge_pkg::cmd_t       cmd_q;
  logic                       is_read;
  logic                       data_take;

  assign is_read   = (cmd_q.grp == pin_bridge_pkg::GRP_PIN_RD) ||
                     (cmd_q.grp == pin_bridge_pkg::GRP_REG_RD);
  assign data_take = (state == pin_bridge_pkg::WAIT_DATA) && data_valid;

  always_comb begin
    state_nxt = state;
    case (state)
      pin_bridge_pkg::IDLE: if (cmd_valid) state_nxt = pin_bridge_pkg::EXEC;
      pin_bridge_pkg::EXEC: begin
        case (cmd_q.grp)
          pin_bridge_pkg::GRP_PIN_WR,
          pin_bridge_pkg::GRP_REG_WR: state_nxt = pin_bridge_pkg::WAIT_DATA;
          pin_bridge_pkg::GRP_PIN_RD,
          pin_bridge_pkg::GRP_REG_RD: begin
            state_nxt = resp_ready ? pin_bridge_pkg::DONE : pin_bridge_pkg::WAIT_RESP;
          end
          default: state_nxt = pin_bridge_pkg::DONE; // strobe, release, unknown
        endcase
      end
      pin_bridge_pkg::WAIT_DATA: if (data_valid) state_nxt = pin_bridge_pkg::DONE;
      pin_bridge_pkg::WAIT_RESP: if (resp_ready) state_nxt = pin_bridge_pkg::DONE;
      pin_bridge_pkg::DONE:      state_nxt = pin_bridge_pkg::IDLE;
      default:                   state_nxt = pin_bridge_pkg::IDLE;
    endcase
  end

  // drop the request in the cycle the captured byte shows up
  assign accept_cmd  = (state == pin_bridge_pkg::IDLE) && !cmd_valid;
  assign accept_data = (state == pin_bridge_pkg::WAIT_DATA) && !data_valid;
  assign busy        = (state != pin_bridge_pkg::IDLE);

  assign rd_idx     = cmd_q.idx;
  assign resp_byte  = (cmd_q.grp == pin_bridge_pkg::GRP_PIN_RD) ? pin_sample : reg_value;
  assign resp_valid = is_read && resp_ready &&
                      ((state == pin_bridge_pkg::EXEC) || (state == pin_bridge_pkg::WAIT_RESP));

  always_comb begin
    port_wr.wr   = data_take && (cmd_q.grp == pin_bridge_pkg::GRP_PIN_WR);
    port_wr.rel  = (state == pin_bridge_pkg::EXEC) && (cmd_q.grp == pin_bridge_pkg::GRP_PIN_REL);
    port_wr.idx  = cmd_q.idx;
    port_wr.data = data;
    reg_wr.wr    = data_take && (cmd_q.grp == pin_bridge_pkg::GRP_REG_WR);
    reg_wr.idx   = cmd_q.idx;
    reg_wr.data  = data;
  end

  always_ff @(posedge sys_clk or negedge sys_rst_n) begin
    if (!sys_rst_n) begin
      state      <= pin_bridge_pkg::IDLE;
      target_clk <= 1'b0;
      target_rst <= 1'b0;
    end else begin
      state <= state_nxt;
      if (state == pin_bridge_pkg::EXEC && cmd_q.grp == pin_bridge_pkg::GRP_STROBE) begin
        case ({1'b0, cmd_q.idx})
          `PB_STROBE_CLK_SET: target_clk <= 1'b1;
          `PB_STROBE_CLK_CLR: target_clk <= 1'b0;
          `PB_STROBE_RST_SET: target_rst <= 1'b1;
          `PB_STROBE_RST_CLR: target_rst <= 1'b0;
          default: ;
        endcase
      end
    end
  end

  always_ff @(posedge sys_clk) begin
    if (state == pin_bridge_pkg::IDLE && cmd_valid) cmd_q <= cmd; // hold for the whole command
  end

  // receiver hands over only what the current state asked for
  a_cmd_in_idle: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
    cmd_valid |-> state == pin_bridge_pkg::IDLE);
  a_data_in_wait: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
    data_valid |-> state == pin_bridge_pkg::WAIT_DATA);

endmodule

/* design/port_bank.sv */
`include "pin_bridge_consts.svh"

module port_bank (
  input  logic                        sys_clk,
  input  logic                        sys_rst_n,
  input  pin_bridge_pkg::port_wr_t    port_wr,
  input  pin_bridge_pkg::port_array_t in_ports,
  input  pin_bridge_pkg::port_idx_t   rd_idx,
  output pin_bridge_pkg::port_array_t out_ports,
  output pin_bridge_pkg::port_mask_t  out_oe,
  output pin_bridge_pkg::byte_t       pin_sample
);

  pin_bridge_pkg::port_array_t in_sync;

  always_ff @(posedge sys_clk or negedge sys_rst_n) begin
    if (!sys_rst_n) begin
      out_ports <= '0;
      out_oe    <= '0;
    end else begin
      if (port_wr.wr) begin
        out_ports[port_wr.idx*`PB_BYTE_W +: `PB_BYTE_W] <= port_wr.data;
        out_oe[port_wr.idx] <= 1'b1;
      end else if (port_wr.rel) begin
        out_oe[port_wr.idx] <= 1'b0; // data stays on the register
      end
    end
  end

  // single capture stage on the async inputs
  always_ff @(posedge sys_clk) begin
    in_sync <= in_ports;
  end

  assign pin_sample = in_sync[rd_idx*`PB_BYTE_W +: `PB_BYTE_W];

endmodule

/* design/user_reg_file.sv */
`include "pin_bridge_consts.svh"

module user_reg_file (
  input  logic                      sys_clk,
  input  logic                      sys_rst_n,
  input  pin_bridge_pkg::reg_wr_t   reg_wr,
  input  pin_bridge_pkg::port_idx_t rd_idx,
  output pin_bridge_pkg::byte_t     reg_value
);

  pin_bridge_pkg::byte_t regs [`PB_NUM_PORTS];

  always_ff @(posedge sys_clk or negedge sys_rst_n) begin
    if (!sys_rst_n) begin
      for (int i = 0; i < `PB_NUM_PORTS; i++) begin
        regs[i] <= '0;
      end
    end else if (reg_wr.wr) begin
      regs[reg_wr.idx] <= reg_wr.data;
    end
  end

  assign reg_value = regs[rd_idx]; // comb read back

endmodule

/* design/resp_buffer.sv */
module resp_buffer (
  input  logic                  sys_clk,
  input  logic                  sys_rst_n,
  input  logic                  resp_valid,
  input  pin_bridge_pkg::byte_t resp_byte,
  input  logic                  tx_ready,
  output logic                  resp_ready,
  output pin_bridge_pkg::byte_t tx_byte,
  output logic                  tx_valid
);

  logic full;

  assign resp_ready = !full; // accepts only when empty
  assign tx_valid   = full;

  always_ff @(posedge sys_clk or negedge sys_rst_n) begin
    if (!sys_rst_n) begin
      full <= 1'b0;
    end else if (resp_valid && !full) begin
      full <= 1'b1;
    end else if (full && tx_ready) begin
      full <= 1'b0;
    end
  end

  always_ff @(posedge sys_clk) begin
    if (resp_valid && !full) tx_byte <= resp_byte;
  end

  // a push into a full entry would lose a byte
  a_no_overrun: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
    resp_valid |-> !full);

endmodule

/* design/pin_bridge_top.sv */
module pin_bridge_top (
  input  logic                        sys_clk,
  input  logic                        sys_rst_n,
  input  pin_bridge_pkg::byte_t       rx_byte,
  input  logic                        rx_valid,
  output logic                        rx_ready,
  output pin_bridge_pkg::byte_t       tx_byte,
  output logic                        tx_valid,
  input  logic                        tx_ready,
  input  pin_bridge_pkg::port_array_t in_ports,
  output pin_bridge_pkg::port_array_t out_ports,
  output pin_bridge_pkg::port_mask_t  out_oe,
  output logic                        target_clk,
  output logic                        target_rst,
  output logic                        busy
);

  pin_bridge_pkg::cmd_t      cmd;
  logic                      cmd_valid;
  pin_bridge_pkg::byte_t     data;
  logic                      data_valid;
  logic                      accept_cmd;
  logic                      accept_data;
  pin_bridge_pkg::port_wr_t  port_wr;
  pin_bridge_pkg::reg_wr_t   reg_wr;
  pin_bridge_pkg::port_idx_t rd_idx;
  logic                      resp_valid;
  pin_bridge_pkg::byte_t     resp_byte;
  logic                      resp_ready;
  pin_bridge_pkg::byte_t     pin_sample;
  pin_bridge_pkg::byte_t     reg_value;

  cmd_receiver u_rx (
    .sys_clk, .sys_rst_n, .rx_byte, .rx_valid, .accept_cmd, .accept_data,
    .rx_ready, .cmd, .cmd_valid, .data, .data_valid
  );

  cmd_sequencer u_seq (
    .sys_clk, .sys_rst_n, .cmd, .cmd_valid, .data, .data_valid, .resp_ready,
    .pin_sample, .reg_value, .accept_cmd, .accept_data, .port_wr, .reg_wr,
    .rd_idx, .resp_valid, .resp_byte, .target_clk, .target_rst, .busy
  );

  port_bank u_ports (
    .sys_clk, .sys_rst_n, .port_wr, .in_ports, .rd_idx,
    .out_ports, .out_oe, .pin_sample
  );

  user_reg_file u_regs (
    .sys_clk, .sys_rst_n, .reg_wr, .rd_idx, .reg_value
  );

  resp_buffer u_resp (
    .sys_clk, .sys_rst_n, .resp_valid, .resp_byte, .tx_ready,
    .resp_ready, .tx_byte, .tx_valid
  );

endmodule

/* tb/pin_bridge_model.svh */
// expected DUT state, kept in step with every command sent
pin_bridge_pkg::port_array_t exp_ports;
pin_bridge_pkg::port_mask_t  exp_oe;
pin_bridge_pkg::byte_t       exp_regs [`PB_NUM_PORTS];
pin_bridge_pkg::byte_t       exp_resp [$]; // responses still due, oldest first
logic                        exp_clk;
logic                        exp_rst;

// write opcodes take a second byte from the stream
function automatic logic needs_data(input pin_bridge_pkg::byte_t op);
  return !op[3] && (op[7:4] == `PB_GRP_PIN_WR || op[7:4] == `PB_GRP_REG_WR);
endfunction

task automatic reset_model();
  exp_ports = '0;
  exp_oe    = '0;
  exp_clk   = 1'b0;
  exp_rst   = 1'b0;
  foreach (exp_regs[i]) exp_regs[i] = '0;
endtask

// 0x00 and undefined opcodes fall through with no effect
task automatic apply_command(input pin_bridge_pkg::byte_t op, input pin_bridge_pkg::byte_t d,
                             input pin_bridge_pkg::port_array_t pins);
  pin_bridge_pkg::port_idx_t idx;
  idx = op[2:0];
  if (!op[3]) begin
    case (op[7:4])
      `PB_GRP_STROBE: begin
        case (op[3:0])
          `PB_STROBE_CLK_SET: exp_clk = 1'b1;
          `PB_STROBE_CLK_CLR: exp_clk = 1'b0;
          `PB_STROBE_RST_SET: exp_rst = 1'b1;
          `PB_STROBE_RST_CLR: exp_rst = 1'b0;
          default: ;
        endcase
      end
      `PB_GRP_PIN_RD:  exp_resp.push_back(pins[idx*`PB_BYTE_W +: `PB_BYTE_W]);
      `PB_GRP_PIN_WR: begin
        exp_ports[idx*`PB_BYTE_W +: `PB_BYTE_W] = d;
        exp_oe[idx] = 1'b1;
      end
      `PB_GRP_REG_WR:  exp_regs[idx] = d;
      `PB_GRP_REG_RD:  exp_resp.push_back(exp_regs[idx]);
      `PB_GRP_PIN_REL: exp_oe[idx] = 1'b0; // data kept
      default: ;
    endcase
  end
endtask

/* tb/pin_bridge_tb.sv */
`include "pin_bridge_consts.svh"

module pin_bridge_tb;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int CLK_PERIOD  = 40;
  localparam int RST_CYCLES  = 4;
  localparam int NUM_CMDS    = 400;
  localparam int CMD_MAX_CYC = 60; // gaps, two bytes and tx stalls
  localparam int WATCHDOG_NS = CLK_PERIOD * (RST_CYCLES + NUM_CMDS * CMD_MAX_CYC);

  logic                        sys_clk;
  logic                        sys_rst_n;
  pin_bridge_pkg::byte_t       rx_byte;
  logic                        rx_valid;
  logic                        rx_ready;
  pin_bridge_pkg::byte_t       tx_byte;
  logic                        tx_valid;
  logic                        tx_ready;
  pin_bridge_pkg::port_array_t in_ports;
  pin_bridge_pkg::port_array_t out_ports;
  pin_bridge_pkg::port_mask_t  out_oe;
  logic                        target_clk;
  logic                        target_rst;
  logic                        busy;
  logic [31:0]                 stim_lfsr;
  logic [31:0]                 bp_lfsr;

  `include "pin_bridge_model.svh"

  pin_bridge_top u_dut (.*);

  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1); // galois, taps 32 22 2 1
  endfunction

  function automatic logic [31:0] draw(inout logic [31:0] st, input int nbits);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < nbits; i++) begin
      v  = {v[30:0], st[0]};
      st = lfsr_step(st);
    end
    return v;
  endfunction

  task automatic report_failure(input string msg);
    $display("%s", msg);
    $display("TEST RESULT: FAIL");
    $fatal(1, "simulation stopped");
  endtask

  task automatic mismatch(input string name, input logic [63:0] got, input logic [63:0] want);
    report_failure($sformatf("CHECK FAILED time %0t signal %s got %0h expected %0h",
                             $time, name, got, want));
  endtask

  task automatic check_byte(input string name, input pin_bridge_pkg::byte_t got,
                            input pin_bridge_pkg::byte_t want);
    if (got !== want) mismatch(name, 64'(got), 64'(want));
  endtask

  task automatic check_ports(input string name, input pin_bridge_pkg::port_array_t got,
                             input pin_bridge_pkg::port_array_t want);
    if (got !== want) mismatch(name, got, want);
  endtask

  task automatic check_mask(input string name, input pin_bridge_pkg::port_mask_t got,
                            input pin_bridge_pkg::port_mask_t want);
    if (got !== want) mismatch(name, 64'(got), 64'(want));
  endtask

  task automatic check_bit(input string name, input logic got, input logic want);
    if (got !== want) mismatch(name, 64'(got), 64'(want));
  endtask

  task automatic check_outputs();
    check_ports("out_ports", out_ports, exp_ports);
    check_mask("out_oe", out_oe, exp_oe);
    check_bit("target_clk", target_clk, exp_clk);
    check_bit("target_rst", target_rst, exp_rst);
  endtask

  // byte moves on the posedge after a negedge with valid and ready high
  task automatic send_byte(input pin_bridge_pkg::byte_t b);
    repeat (draw(stim_lfsr, 2)) @(negedge sys_clk); // random gap
    rx_byte  = b;
    rx_valid = 1'b1;
    while (!rx_ready) @(negedge sys_clk);
    @(negedge sys_clk);
    rx_valid = 1'b0;
  endtask

  // busy shows one cycle after the command byte is taken
  task automatic wait_done(input logic busy_due);
    @(negedge sys_clk);
    check_bit("busy", busy, busy_due);
    while (busy) @(negedge sys_clk);
  endtask

  initial begin
    sys_clk = 1'b0;
    forever #(CLK_PERIOD / 2) sys_clk = ~sys_clk;
  end

  initial begin
    #(WATCHDOG_NS);
    report_failure("watchdog expired before all commands and responses completed");
  end

  // outgoing stream with random back-pressure, responses checked in order
  initial begin
    tx_ready = 1'b0;
    bp_lfsr  = 32'h29f30314;
    void'(draw(bp_lfsr, 17)); // offset from the stimulus stream
    forever begin
      @(negedge sys_clk);
      tx_ready = 1'(draw(bp_lfsr, 1));
      if (tx_valid && tx_ready) begin
        if (exp_resp.size() == 0) begin
          report_failure("a response byte arrived that no command asked for");
        end else begin
          check_byte("tx_byte", tx_byte, exp_resp.pop_front());
        end
      end
    end
  end

  initial begin
    pin_bridge_pkg::byte_t     op;
    pin_bridge_pkg::byte_t     d;
    pin_bridge_pkg::port_idx_t idx;
    logic [2:0]                sel;
    sys_rst_n = 1'b0;
    rx_byte   = '0;
    rx_valid  = 1'b0;
    in_ports  = '0;
    stim_lfsr = 32'h29f30314;
    reset_model();
    repeat (RST_CYCLES) @(negedge sys_clk);
    sys_rst_n = 1'b1;
    check_bit("rx_ready", rx_ready, 1'b1);
    check_bit("tx_valid", tx_valid, 1'b0);
    check_bit("busy", busy, 1'b0);
    check_outputs();
    for (int n = 0; n < NUM_CMDS; n++) begin
      sel = 3'(draw(stim_lfsr, 3));
      idx = 3'(draw(stim_lfsr, 3));
      case (sel)
        3'd0:    op = {`PB_GRP_STROBE, 2'b00, idx[1:0]};
        3'd1:    op = {`PB_GRP_PIN_RD, 1'b0, idx};
        3'd2,
        3'd6:    op = {`PB_GRP_PIN_WR, 1'b0, idx};
        3'd3:    op = {`PB_GRP_REG_WR, 1'b0, idx};
        3'd4:    op = {`PB_GRP_REG_RD, 1'b0, idx};
        3'd5:    op = {`PB_GRP_PIN_REL, 1'b0, idx};
        default: op = 8'(draw(stim_lfsr, 8)); // mostly undefined opcodes
      endcase
      d        = 8'(draw(stim_lfsr, 8));
      in_ports = {draw(stim_lfsr, 32), draw(stim_lfsr, 32)}; // stable for the whole command
      apply_command(op, d, in_ports);
      send_byte(op);
      if (needs_data(op)) send_byte(d);
      wait_done(op != 8'h00); // 0x00 never starts a command
      check_outputs();
    end
    while (exp_resp.size() != 0) @(negedge sys_clk);
    @(negedge sys_clk);
    check_bit("tx_valid", tx_valid, 1'b0);
    $display("TEST RESULT: PASS");
    $finish;
  end

endmodule

/* pin_bridge.f */
+incdir+design
+incdir+tb
design/pin_bridge_pkg.sv
design/cmd_receiver.sv
design/cmd_sequencer.sv
design/port_bank.sv
design/user_reg_file.sv
design/resp_buffer.sv
design/pin_bridge_top.sv
tb/pin_bridge_tb.sv

/* run_sim.sh */
#!/bin/sh
# build the testbench with Verilator and run it, status follows the pass line
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --timescale 1ns/1ps --top-module pin_bridge_tb \
  -f pin_bridge.f -o pin_bridge_sim &&
./obj_dir/pin_bridge_sim | tee /dev/stderr | grep -q "^TEST RESULT: PASS$" &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }
